/* design/core_params.svh */
////////////////////////////////////////////////////////////
// core parameters
// bridge register map, reset stretch length, video sync
// shaping delay and save table constants
////////////////////////////////////////////////////////////
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// bridge word addresses of the core settings
`define CORE_ADDR_RESET      32'h050
`define CORE_ADDR_SYSTEM     32'h100
`define CORE_ADDR_TURBO      32'h110
`define CORE_ADDR_TRIPLE_BUF 32'h200
`define CORE_ADDR_FLICKER    32'h204
`define CORE_ADDR_ORIENT     32'h208
`define CORE_ADDR_FLIP_H     32'h20C
`define CORE_ADDR_FF_SOUND   32'h300

// cycles the external reset is held after a reset write
`define CORE_RESET_STRETCH 256

// hsync is pushed out this many cycles so it never meets vsync
`define CORE_HS_DELAY 7

// data slot index, not slot id
`define CORE_SLOT_INDEX 3

// save length terms
`define CORE_SAVE_BLOCK_BYTES 512
`define CORE_RTC_BYTES        12

`endif

/* design/bridge_pkg.sv */
////////////////////////////////////////////////////////////
// bridge types
// host bridge words, core settings and data table writes
////////////////////////////////////////////////////////////
package bridge_pkg;

  // bridge address and data words
  typedef logic [31:0] bridge_word_t;

  // data slot table address
  typedef logic [9:0] table_addr_t;

  // save size in 512-byte blocks
  typedef logic [11:0] save_blocks_t;

  typedef enum logic [1:0] {
    ORIENT_AUTO           = 2'd0,
    ORIENT_HORIZONTAL     = 2'd1,
    ORIENT_VERTICAL       = 2'd2,
    ORIENT_HORIZONTAL_ALT = 2'd3
  } orientation_e;

  typedef struct packed {
    logic [1:0]   system;
    logic         cpu_turbo;
    logic         triple_buffer;
    logic [1:0]   flickerblend;
    orientation_e orientation;
    logic         flip_h;
    logic         ff_sound;
  } core_settings_t;

  typedef struct packed {
    logic         wren;
    table_addr_t  addr;
    bridge_word_t data;
  } datatable_wr_t;

endpackage

/* design/video_pkg.sv */
////////////////////////////////////////////////////////////
// video types
// core video stream and the scaler facing output
////////////////////////////////////////////////////////////
package video_pkg;

  // 8 bits each of r, g, b
  typedef logic [23:0] pixel_t;

  // raw stream straight from the console core
  typedef struct packed {
    logic   hblank;
    logic   vblank;
    logic   hsync;
    logic   vsync;
    logic   is_vertical;
    pixel_t rgb;
  } core_video_t;

  // registered stream to the scaler
  typedef struct packed {
    logic   de;
    logic   hs;
    logic   vs;
    pixel_t rgb;
  } video_out_t;

endpackage

/* design/core_bridge_regs.sv */
////////////////////////////////////////////////////////////
// core bridge registers
// decodes host bridge writes into the settings, stretches
// the external reset and reports the save length
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "core_params.svh"

module core_bridge_regs (
  input  logic                       clk_74a,
  input  logic                       pll_core_locked,
  input  bridge_pkg::bridge_word_t   bridge_addr,
  input  logic                       bridge_wr,
  input  bridge_pkg::bridge_word_t   bridge_wr_data,
  input  bridge_pkg::save_blocks_t   save_size,
  input  logic                       has_rtc,
  output bridge_pkg::core_settings_t settings,
  output logic                       external_reset,
  output bridge_pkg::datatable_wr_t  datatable
);

  import bridge_pkg::*;

  localparam int RST_W = $clog2(`CORE_RESET_STRETCH + 1);

  logic [RST_W-1:0] reset_cnt;
  logic             reset_wr;

  ////////////////////////////////////////////////////////////
  // settings registers

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      settings <= '0;
    end else if (bridge_wr) begin
      case (bridge_addr)
        `CORE_ADDR_SYSTEM: begin
          settings.system <= bridge_wr_data[1:0];
        end
        `CORE_ADDR_TURBO: begin
          settings.cpu_turbo <= bridge_wr_data[0];
        end
        `CORE_ADDR_TRIPLE_BUF: begin
          settings.triple_buffer <= bridge_wr_data[0];
        end
        `CORE_ADDR_FLICKER: begin
          settings.flickerblend <= bridge_wr_data[1:0];
        end
        `CORE_ADDR_ORIENT: begin
          settings.orientation <= orientation_e'(bridge_wr_data[1:0]);
        end
        `CORE_ADDR_FLIP_H: begin
          settings.flip_h <= bridge_wr_data[0];
        end
        `CORE_ADDR_FF_SOUND: begin
          settings.ff_sound <= bridge_wr_data[0];
        end
        default: begin
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // reset stretcher

  assign reset_wr = bridge_wr && (bridge_addr == `CORE_ADDR_RESET);

  // a fresh write restarts the count from the top
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      reset_cnt <= '0;
    end else if (reset_wr) begin
      reset_cnt <= RST_W'(`CORE_RESET_STRETCH);
    end else if (reset_cnt != '0) begin
      reset_cnt <= reset_cnt - RST_W'(1);
    end
  end

  // high while the count runs down
  assign external_reset = (reset_cnt != '0);

  ////////////////////////////////////////////////////////////
  // save length table entry

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      datatable <= '0;
    end else begin
      datatable.wren <= 1'b1;
      // odd entry of the slot holds the length
      datatable.addr <= table_addr_t'(2 * `CORE_SLOT_INDEX + 1);
      // rtc adds six 16-bit words after the save data
      datatable.data <= bridge_word_t'(save_size) * `CORE_SAVE_BLOCK_BYTES
                        + (has_rtc ? `CORE_RTC_BYTES : 0);
    end
  end

endmodule

/* design/video_sync_shaper.sv */
////////////////////////////////////////////////////////////
// video sync shaper
// turns the core syncs into single-cycle pulses, with hsync
// delayed so it never lands on the vsync pulse
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "core_params.svh"

module video_sync_shaper (
  input  logic clk_74a,
  input  logic pll_core_locked,
  input  logic hsync_in,
  input  logic vsync_in,
  output logic hs,
  output logic vs
);

  localparam int HS_W = $clog2(`CORE_HS_DELAY + 1);

  logic            hsync_prev;
  logic            vsync_prev;
  logic [HS_W-1:0] hs_cnt;

  // previous samples for edge detect
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hsync_prev <= 1'b0;
      vsync_prev <= 1'b0;
    end else begin
      hsync_prev <= hsync_in;
      vsync_prev <= vsync_in;
    end
  end

  // vsync pulse on the rising edge
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      vs <= 1'b0;
    end else begin
      vs <= vsync_in && !vsync_prev;
    end
  end

  // hsync delay counter, a new rising edge reloads it
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hs_cnt <= '0;
      hs     <= 1'b0;
    end else begin
      hs <= (hs_cnt == HS_W'(1));
      if (hsync_in && !hsync_prev) begin
        hs_cnt <= HS_W'(`CORE_HS_DELAY);
      end else if (hs_cnt != '0) begin
        hs_cnt <= hs_cnt - HS_W'(1);
      end
    end
  end

endmodule

/* design/video_pixel_path.sv */
////////////////////////////////////////////////////////////
// video pixel path
// data enable from the blanks, registered pixels and the
// orientation slot word after each active line
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module video_pixel_path (
  input  logic                     clk_74a,
  input  logic                     pll_core_locked,
  input  video_pkg::core_video_t   core_video,
  input  bridge_pkg::orientation_e orientation,
  output logic                     de,
  output video_pkg::pixel_t        rgb
);

  import video_pkg::*;
  import bridge_pkg::*;

  logic   de_now;
  logic   orient_sel;
  pixel_t slot_word;

  assign de_now = !(core_video.hblank || core_video.vblank);

  // any vertical orientation selects the second scaler slot
  always_comb begin
    case (orientation)
      ORIENT_AUTO:     orient_sel = core_video.is_vertical;
      ORIENT_VERTICAL: orient_sel = 1'b1;
      default:         orient_sel = 1'b0;
    endcase
  end

  // slot select lives in bit 13
  assign slot_word = {10'b0, orient_sel, 13'b0};

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      de  <= 1'b0;
      rgb <= '0;
    end else begin
      de <= de_now;
      if (de_now) begin
        rgb <= core_video.rgb;
      end else if (de) begin
        // trailing edge of the line
        rgb <= slot_word;
      end else begin
        rgb <= '0;
      end
    end
  end

endmodule

/* design/core_top.sv */
////////////////////////////////////////////////////////////
// core top level
// bridge settings, reset stretcher, save table writer and
// video output conditioning on the bridge clock
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module core_top (
  input  logic                       clk_74a,
  input  logic                       pll_core_locked,
  input  bridge_pkg::bridge_word_t   bridge_addr,
  input  logic                       bridge_wr,
  input  bridge_pkg::bridge_word_t   bridge_wr_data,
  input  bridge_pkg::save_blocks_t   save_size,
  input  logic                       has_rtc,
  input  video_pkg::core_video_t     core_video,
  output bridge_pkg::core_settings_t settings,
  output logic                       external_reset,
  output bridge_pkg::datatable_wr_t  datatable,
  output video_pkg::video_out_t      video_out
);

  import video_pkg::*;

  logic   vid_hs;
  logic   vid_vs;
  logic   vid_de;
  pixel_t vid_rgb;

  core_bridge_regs u_bridge (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .save_size      (save_size),
    .has_rtc        (has_rtc),
    .settings       (settings),
    .external_reset (external_reset),
    .datatable      (datatable)
  );

  video_sync_shaper u_sync (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .hsync_in       (core_video.hsync),
    .vsync_in       (core_video.vsync),
    .hs             (vid_hs),
    .vs             (vid_vs)
  );

  video_pixel_path u_pixel (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .core_video     (core_video),
    .orientation    (settings.orientation),
    .de             (vid_de),
    .rgb            (vid_rgb)
  );

  assign video_out = '{de: vid_de, hs: vid_hs, vs: vid_vs, rgb: vid_rgb};

endmodule

/* tb/core_top_asserts.sv */
////////////////////////////////////////////////////////////
// core top assertions
// sync pulse widths and overlap, blanked pixels and the
// external reset against its counter
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "core_params.svh"

module core_top_asserts #(
  parameter int RST_W = $clog2(`CORE_RESET_STRETCH + 1)
) (
  input logic                  clk_74a,
  input logic                  pll_core_locked,
  input video_pkg::video_out_t video_out,
  input logic                  external_reset,
  input logic [RST_W-1:0]      reset_cnt
);

  vs_one_cycle: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    video_out.vs |=> !video_out.vs)
    else $error("vs pulse lasted more than one cycle");

  hs_one_cycle: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    video_out.hs |=> !video_out.hs)
    else $error("hs pulse lasted more than one cycle");

  sync_apart: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    !(video_out.hs && video_out.vs))
    else $error("hs and vs high together");

  // only the slot word may show while blanked
  rgb_blanked: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    (!video_out.de && !$past(video_out.de)) |-> (video_out.rgb == '0))
    else $error("rgb not zero during blanking");

  // a running stretch steps down by one unless a new write reloads it
  reset_countdown: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    external_reset |=> (reset_cnt == $past(reset_cnt) - RST_W'(1))
                       || (reset_cnt == RST_W'(`CORE_RESET_STRETCH)))
    else $error("external_reset counter skipped a step");

endmodule

bind core_top core_top_asserts u_asserts (
  .clk_74a        (clk_74a),
  .pll_core_locked(pll_core_locked),
  .video_out      (video_out),
  .external_reset (external_reset),
  .reset_cnt      (u_bridge.reset_cnt)
);

/* tb/core_top_tb.sv */
////////////////////////////////////////////////////////////
// core top testbench
// seeded random bridge, save and raster stimulus checked
// every cycle against a reference model
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "core_params.svh"

module core_top_tb;

  import bridge_pkg::*;
  import video_pkg::*;

  localparam int TEST_CYCLES  = 2000;
  localparam int LIMIT_CYCLES = 2 * TEST_CYCLES;
  localparam int RESET_CYCLES = 5;

  logic           clk_74a;
  logic           pll_core_locked;
  bridge_word_t   bridge_addr;
  logic           bridge_wr;
  bridge_word_t   bridge_wr_data;
  save_blocks_t   save_size;
  logic           has_rtc;
  core_video_t    core_video;
  core_settings_t settings;
  logic           external_reset;
  datatable_wr_t  datatable;
  video_out_t     video_out;

  integer seed        = 13562;
  int     cycle_count = 0;
  int     mismatches  = 0;

  // reference model state
  core_settings_t m_settings;
  datatable_wr_t  m_table;
  video_out_t     m_video;
  int             m_reset_left;
  logic           m_vsync_prev;
  logic           m_hsync_prev;
  logic           m_de_prev;
  int             m_edge;
  int             m_hs_due;

  // raster position
  int h_pos;
  int line_no;
  int hblank_len;
  int line_len;

  core_top u_dut (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .save_size      (save_size),
    .has_rtc        (has_rtc),
    .core_video     (core_video),
    .settings       (settings),
    .external_reset (external_reset),
    .datatable      (datatable),
    .video_out      (video_out)
  );

  initial begin
    clk_74a = 1'b0;
    forever #4 clk_74a = ~clk_74a;
  end

  always @(posedge clk_74a) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= LIMIT_CYCLES) begin
      $display("timeout: the test did not finish within %0d cycles", LIMIT_CYCLES);
      fail_run();
    end
  end

  task automatic fail_run();
    $display("Simulation FAILED");
    $fatal(1, "run stopped");
  endtask

  ////////////////////////////////////////////////////////////
  // compare tasks

  task automatic check_settings(core_settings_t got, core_settings_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("ERROR at %0t: settings got %h expected %h", $time, got, exp);
      fail_run();
    end
  endtask

  task automatic check_reset(logic got, logic exp);
    if (got !== exp) begin
      mismatches++;
      $display("ERROR at %0t: external_reset got %b expected %b", $time, got, exp);
      fail_run();
    end
  endtask

  task automatic check_datatable(datatable_wr_t got, datatable_wr_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("ERROR at %0t: datatable got %h expected %h", $time, got, exp);
      fail_run();
    end
  endtask

  task automatic check_video(video_out_t got, video_out_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("ERROR at %0t: video_out got %h expected %h", $time, got, exp);
      fail_run();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // reference model stepped on each rising edge

  task automatic clear_model();
    m_settings   = '0;
    m_table      = '0;
    m_video      = '0;
    m_reset_left = 0;
    m_vsync_prev = 1'b0;
    m_hsync_prev = 1'b0;
    m_de_prev    = 1'b0;
    m_edge       = 0;
    m_hs_due     = -1;
  endtask

  task automatic step_model();
    logic active;
    logic slot_bit;
    int   length;
    if (!pll_core_locked) begin
      clear_model();
      return;
    end
    active = !core_video.hblank && !core_video.vblank;
    // orientation still holds its value from before this edge
    if (m_settings.orientation == ORIENT_VERTICAL) slot_bit = 1'b1;
    else if (m_settings.orientation == ORIENT_AUTO) slot_bit = core_video.is_vertical;
    else slot_bit = 1'b0;
    m_video.de  = active;
    m_video.vs  = core_video.vsync && !m_vsync_prev;
    m_video.hs  = (m_edge == m_hs_due);
    m_video.rgb = '0;
    if (active) m_video.rgb = core_video.rgb;
    else if (m_de_prev) m_video.rgb[13] = slot_bit;
    // latest hsync rise sets the pulse edge
    if (core_video.hsync && !m_hsync_prev) m_hs_due = m_edge + `CORE_HS_DELAY;
    m_vsync_prev = core_video.vsync;
    m_hsync_prev = core_video.hsync;
    m_de_prev    = active;
    m_edge++;
    length = int'(save_size) * `CORE_SAVE_BLOCK_BYTES;
    if (has_rtc) length += `CORE_RTC_BYTES;
    m_table.wren = 1'b1;
    // length entry of slot 3
    m_table.addr = 10'd7;
    m_table.data = bridge_word_t'(length);
    if (m_reset_left > 0) m_reset_left--;
    if (bridge_wr) begin
      case (bridge_addr)
        `CORE_ADDR_RESET:      m_reset_left = `CORE_RESET_STRETCH;
        `CORE_ADDR_SYSTEM:     m_settings.system = bridge_wr_data[1:0];
        `CORE_ADDR_TURBO:      m_settings.cpu_turbo = bridge_wr_data[0];
        `CORE_ADDR_TRIPLE_BUF: m_settings.triple_buffer = bridge_wr_data[0];
        `CORE_ADDR_FLICKER:    m_settings.flickerblend = bridge_wr_data[1:0];
        `CORE_ADDR_ORIENT:     m_settings.orientation = orientation_e'(bridge_wr_data[1:0]);
        `CORE_ADDR_FLIP_H:     m_settings.flip_h = bridge_wr_data[0];
        `CORE_ADDR_FF_SOUND:   m_settings.ff_sound = bridge_wr_data[0];
        default: begin
        end
      endcase
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus

  function automatic bridge_word_t settings_addr(logic [2:0] idx);
    case (idx)
      3'd0:    return `CORE_ADDR_SYSTEM;
      3'd1:    return `CORE_ADDR_TURBO;
      3'd2:    return `CORE_ADDR_TRIPLE_BUF;
      3'd3:    return `CORE_ADDR_FLICKER;
      3'd4:    return `CORE_ADDR_ORIENT;
      3'd5:    return `CORE_ADDR_FLIP_H;
      default: return `CORE_ADDR_FF_SOUND;
    endcase
  endfunction

  task automatic drive_inputs(int cyc);
    bridge_word_t rb;
    bridge_word_t rv;
    rb = $random(seed);
    rv = $random(seed);
    bridge_wr_data = $random(seed);
    bridge_wr      = (rb[5:4] == 2'b00);
    // word aligned addresses below 0x400 also hit the map now and then
    if (rb[3]) bridge_addr = {22'b0, rb[15:8], 2'b00};
    else bridge_addr = settings_addr(rb[2:0]);
    // second write restarts the stretch before it runs out
    if (cyc == 20 || cyc == 120 || cyc == 700) begin
      bridge_wr   = 1'b1;
      bridge_addr = `CORE_ADDR_RESET;
    end
    save_size = rb[27:16];
    has_rtc   = rb[28];
    // random blank and active widths per line
    if (h_pos == 0) begin
      hblank_len = 9 + int'(rv[27:25]);
      line_len   = hblank_len + 4 + int'(rv[31:28]);
    end
    core_video.hsync       = (h_pos < 2);
    core_video.vsync       = (line_no == 0) && (h_pos < 3);
    core_video.hblank      = (h_pos < hblank_len);
    core_video.vblank      = (line_no < 2);
    core_video.is_vertical = rv[24];
    core_video.rgb         = rv[23:0];
    h_pos++;
    if (h_pos == line_len) begin
      h_pos   = 0;
      line_no = (line_no + 1) % 6;
    end
  endtask

  initial begin
    pll_core_locked = 1'b0;
    bridge_addr     = '0;
    bridge_wr       = 1'b0;
    bridge_wr_data  = '0;
    save_size       = '0;
    has_rtc         = 1'b0;
    core_video      = '0;
    h_pos           = 0;
    line_no         = 0;
    hblank_len      = 0;
    line_len        = 1;
    clear_model();
    for (int cyc = 0; cyc < TEST_CYCLES; cyc++) begin
      @(posedge clk_74a);
      step_model();
      #1;
      if (cyc == RESET_CYCLES - 1) pll_core_locked = 1'b1;
      if (cyc >= RESET_CYCLES) drive_inputs(cyc);
      @(negedge clk_74a);
      check_settings(settings, m_settings);
      check_reset(external_reset, m_reset_left > 0);
      check_datatable(datatable, m_table);
      check_video(video_out, m_video);
    end
    if (mismatches == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      fail_run();
    end
  end

endmodule

/* pocket_core_io.f */
+incdir+design
design/bridge_pkg.sv
design/video_pkg.sv
design/core_bridge_regs.sv
design/video_sync_shaper.sv
design/video_pixel_path.sv
design/core_top.sv
tb/core_top_asserts.sv
tb/core_top_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= core_top_tb
FILELIST  ?= pocket_core_io.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_TEXT ?= Simulation PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
